//--- all.f
hw/renamePkg.sv
hw/renameTable.sv
hw/freeList.sv
hw/dispatchControl.sv
hw/renameStage.sv
tb/renameStage_chk.sv
tb/renameStageTb.sv

//--- tb/renameStageTb.sv
////////////////////////////////////////////////////////////
// Commit returns only tags that the model has handed out, and
// restores are driven only while FREEZE is high
////////////////////////////////////////////////////////////

module renameStageTb;

  localparam int TIMEOUT_CYCLES = 3000;

  logic                                          CLK;
  logic                                          RESET;
  logic                                          FREEZE;
  logic                                          decodeEmpty;
  logic                                          decodePop;
  renamePkg::archReg_t                           srcArch1;
  renamePkg::archReg_t                           srcArch2;
  renamePkg::archReg_t                           destArch;
  logic                                          regWrite;
  logic                                          link;
  logic                                          memRead;
  logic                                          memWrite;
  logic [renamePkg::PAYLOAD_WIDTH-1:0]           payload;
  logic                                          iqFull;
  logic                                          lsqFull;
  logic                                          robFull;
  renamePkg::robIdx_t                            robTail;
  logic                                          iqPush;
  logic                                          lsqPush;
  logic                                          robPush;
  renamePkg::dispatchPacket_t                    issuePacket;
  logic                                          freeReq;
  renamePkg::physTag_t                           freeTag;
  logic                                          freeFull;
  logic                                          restoreReq;
  renamePkg::physTag_t [renamePkg::ARCH_REGS-1:0] restoreMap;

  // Reference model state
  renamePkg::physTag_t        modelTable [renamePkg::ARCH_REGS];
  renamePkg::physTag_t        freeQ [$];
  renamePkg::physTag_t        inUse [$];
  renamePkg::dispatchPacket_t pendingPacket;
  logic                       pendingValid = 1'b0;
  logic                       headTaken = 1'b0;
  renamePkg::archReg_t        lastDest = '0;
  int                         seed = 97768;
  int                         cycleCount = 0;

  renameStage i_renameStage (
    .CLK        (CLK),
    .RESET      (RESET),
    .FREEZE     (FREEZE),
    .decodeEmpty(decodeEmpty),
    .decodePop  (decodePop),
    .srcArch1   (srcArch1),
    .srcArch2   (srcArch2),
    .destArch   (destArch),
    .regWrite   (regWrite),
    .link       (link),
    .memRead    (memRead),
    .memWrite   (memWrite),
    .payload    (payload),
    .iqFull     (iqFull),
    .lsqFull    (lsqFull),
    .robFull    (robFull),
    .robTail    (robTail),
    .iqPush     (iqPush),
    .lsqPush    (lsqPush),
    .robPush    (robPush),
    .issuePacket(issuePacket),
    .freeReq    (freeReq),
    .freeTag    (freeTag),
    .freeFull   (freeFull),
    .restoreReq (restoreReq),
    .restoreMap (restoreMap)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  function automatic int randBelow(input int limit);
    return ($random(seed) & 32'h7fff_ffff) % limit;
  endfunction

  // Advance rule applied to the model state and the current inputs
  function automatic logic expectedAdvance();
    logic needsDest;
    logic memOp;
    logic targetFull;
    needsDest = regWrite || link;
    memOp = memRead || memWrite;
    targetFull = memOp ? lsqFull : iqFull;
    return !FREEZE && !decodeEmpty && !robFull && !targetFull &&
           !(needsDest && freeQ.size() == 0);
  endfunction

  // Only valid when an advance is expected
  function automatic renamePkg::dispatchPacket_t expectedPacket();
    renamePkg::dispatchPacket_t pkt;
    pkt.payload = payload;
    pkt.robTail = robTail;
    pkt.physSrc1 = modelTable[srcArch1];
    pkt.physSrc2 = modelTable[srcArch2];
    pkt.destNeeded = regWrite || link;
    pkt.isMem = memRead || memWrite;
    pkt.physDest = pkt.destNeeded ? freeQ[0] : '0;
    pkt.archDest = destArch;
    return pkt;
  endfunction

  task automatic reportMismatch(input string msg);
    $display("mismatch at time %0t: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic reportFailure(input string msg);
    $display("%s (time %0t)", msg, $time);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic newInstruction();
    int destOdds;
    // Fewer destination writers once the free list runs dry
    destOdds = (freeQ.size() == 0) ? 4 : 2;
    decodeEmpty = 1'b0;
    srcArch1 = renamePkg::archReg_t'(randBelow(renamePkg::ARCH_REGS));
    srcArch2 = renamePkg::archReg_t'(randBelow(renamePkg::ARCH_REGS));
    // Lean on the newest mapping to exercise rename forwarding
    if (randBelow(2) == 0) begin
      srcArch1 = lastDest;
    end
    destArch = renamePkg::archReg_t'(randBelow(renamePkg::ARCH_REGS));
    regWrite = (randBelow(destOdds) == 0);
    link = !regWrite && (randBelow(8) == 0);
    memRead = (randBelow(4) == 0);
    memWrite = !memRead && (randBelow(6) == 0);
    payload = {$random(seed), $random(seed)};
    if (regWrite || link) begin
      lastDest = destArch;
    end
  endtask

  // One cycle of stimulus, then on to 1 unit after the next edge
  task automatic driveCycle(input int returnOdds, input logic allowRestore,
                            input logic allowNew);
    int idx;
    // A held head keeps its fields until it is popped
    if (headTaken || decodeEmpty) begin
      if (allowNew && randBelow(6) != 0) begin
        newInstruction();
      end else begin
        decodeEmpty = 1'b1;
      end
    end
    iqFull = (randBelow(8) == 0);
    lsqFull = (randBelow(8) == 0);
    robFull = (randBelow(10) == 0);
    FREEZE = (randBelow(16) == 0);
    robTail = renamePkg::robIdx_t'(randBelow(64));
    restoreReq = 1'b0;
    if (allowRestore && randBelow(40) == 0) begin
      FREEZE = 1'b1;
      restoreReq = 1'b1;
      for (int i = 0; i < renamePkg::ARCH_REGS; i++) begin
        restoreMap[i] = renamePkg::physTag_t'(randBelow(renamePkg::PHYS_REGS));
      end
    end
    freeReq = 1'b0;
    if (returnOdds > 0 && inUse.size() > 0 && freeQ.size() < renamePkg::PHYS_REGS &&
        randBelow(returnOdds) == 0) begin
      idx = randBelow(inUse.size());
      freeTag = inUse[idx];
      inUse.delete(idx);
      freeReq = 1'b1;
    end
    @(posedge CLK);
    #1;
  endtask

  // Model steps at the falling edge for the rising edge that follows
  always @(negedge CLK) begin
    renamePkg::dispatchPacket_t pkt;
    if (!RESET) begin
      freeQ.delete();
      inUse.delete();
      for (int i = 0; i < renamePkg::ARCH_REGS; i++) begin
        modelTable[i] = renamePkg::physTag_t'(i);
        inUse.push_back(renamePkg::physTag_t'(i));
      end
      for (int i = 0; i < renamePkg::FREE_TAGS; i++) begin
        freeQ.push_back(renamePkg::physTag_t'(renamePkg::ARCH_REGS + i));
      end
      pendingValid = 1'b0;
      headTaken = 1'b0;
    end else begin
      headTaken = expectedAdvance();
      pendingValid = headTaken;
      if (headTaken) begin
        pkt = expectedPacket();
        pendingPacket = pkt;
        if (pkt.destNeeded) begin
          void'(freeQ.pop_front());
          inUse.push_back(pkt.physDest);
          modelTable[destArch] = pkt.physDest;
        end
      end
      // Restore overrides a rename write at the same edge
      if (restoreReq) begin
        for (int i = 0; i < renamePkg::ARCH_REGS; i++) begin
          modelTable[i] = restoreMap[i];
        end
      end
      if (freeReq) begin
        freeQ.push_back(freeTag);
      end
    end
  end

  // Compare process, after the edge and after the stimulus update
  initial begin
    renamePkg::dispatchPacket_t lastPacket;
    logic havePacket;
    havePacket = 1'b0;
    lastPacket = '0;
    forever begin
      @(posedge CLK);
      #2;
      if (RESET) begin
        assert (i_renameStage.i_renameStageChk.failCount == 0)
          else reportFailure("a protocol assertion in the bound checker fired");
        assert (robPush == pendingValid)
          else reportMismatch($sformatf("robPush %b, expected %b", robPush, pendingValid));
        assert (iqPush == (pendingValid && !pendingPacket.isMem))
          else reportMismatch($sformatf("iqPush %b is wrong for this edge", iqPush));
        assert (lsqPush == (pendingValid && pendingPacket.isMem))
          else reportMismatch($sformatf("lsqPush %b is wrong for this edge", lsqPush));
        if (pendingValid) begin
          assert (issuePacket == pendingPacket)
            else reportMismatch($sformatf("issuePacket %h, expected %h",
                                          issuePacket, pendingPacket));
          lastPacket = pendingPacket;
          havePacket = 1'b1;
        end else if (havePacket) begin
          assert (issuePacket == lastPacket)
            else reportMismatch($sformatf("issuePacket changed to %h without a push",
                                          issuePacket));
        end
        assert (decodePop == expectedAdvance())
          else reportMismatch($sformatf("decodePop %b, expected %b",
                                        decodePop, expectedAdvance()));
        assert (freeFull == (freeQ.size() == renamePkg::PHYS_REGS))
          else reportMismatch($sformatf("freeFull %b with %0d tags free",
                                        freeFull, freeQ.size()));
      end
    end
  end

  always @(posedge CLK) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    RESET = 1'b0;
    FREEZE = 1'b0;
    decodeEmpty = 1'b1;
    srcArch1 = '0;
    srcArch2 = '0;
    destArch = '0;
    regWrite = 1'b0;
    link = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    payload = '0;
    iqFull = 1'b0;
    lsqFull = 1'b0;
    robFull = 1'b0;
    robTail = '0;
    freeReq = 1'b0;
    freeTag = '0;
    restoreReq = 1'b0;
    restoreMap = '0;
    repeat (4) @(posedge CLK);
    #1;
    RESET = 1'b1;
    // Allocation from reset, list runs dry, then returns start
    for (int c = 0; c < 400; c++) begin
      driveCycle(0, 1'b0, 1'b1);
    end
    for (int c = 0; c < 400; c++) begin
      driveCycle(4, 1'b0, 1'b1);
    end
    // Mixed traffic with restores under FREEZE
    for (int c = 0; c < 800; c++) begin
      driveCycle(3, 1'b1, 1'b1);
    end
    for (int c = 0; c < 700; c++) begin
      driveCycle(2, 1'b0, 1'b1);
    end
    // Drain the head, then hand every tag back
    while (inUse.size() != 0 || !decodeEmpty) begin
      driveCycle(1, 1'b0, 1'b0);
    end
    repeat (2) driveCycle(0, 1'b0, 1'b0);
    assert (freeQ.size() == renamePkg::PHYS_REGS && freeFull)
      else reportFailure("free list did not report full after all tags came back");
    if (i_renameStage.i_renameStageChk.failCount == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      reportFailure("a protocol assertion in the bound checker fired");
    end
  end

endmodule

//--- tb/renameStage_chk.sv
////////////////////////////////////////////////////////////
// Bound into renameStage; checks other than the reset one
// are idle while RESET is low
////////////////////////////////////////////////////////////

module renameStageChk (
  input logic CLK,
  input logic RESET,
  input logic iqPush,
  input logic lsqPush,
  input logic robPush,
  input logic decodePop,
  input logic decodeEmpty
);

  int failCount = 0;

  // An instruction goes to exactly one queue
  pushExclusive: assert property (@(posedge CLK) disable iff (!RESET)
    !(iqPush && lsqPush))
    else begin
      $error("iqPush and lsqPush high in the same cycle");
      failCount++;
    end

  // Every dispatch also takes a ROB entry
  robFollowsPush: assert property (@(posedge CLK) disable iff (!RESET)
    robPush == (iqPush || lsqPush))
    else begin
      $error("robPush does not match the queue push");
      failCount++;
    end

  popNeedsHead: assert property (@(posedge CLK) disable iff (!RESET)
    !(decodePop && decodeEmpty))
    else begin
      $error("decodePop while the decode queue is empty");
      failCount++;
    end

  resetClearsPushes: assert property (@(posedge CLK)
    !RESET |=> !iqPush && !lsqPush && !robPush)
    else begin
      $error("push strobe high in the cycle after reset");
      failCount++;
    end

endmodule

bind renameStage renameStageChk i_renameStageChk (
  .CLK        (CLK),
  .RESET      (RESET),
  .iqPush     (iqPush),
  .lsqPush    (lsqPush),
  .robPush    (robPush),
  .decodePop  (decodePop),
  .decodeEmpty(decodeEmpty)
);

//--- hw/renameStage.sv
////////////////////////////////////////////////////////////
// One instruction per cycle; commit never pushes a tag while
// freeFull is high, and restore is only used under FREEZE
////////////////////////////////////////////////////////////

module renameStage (
  input  logic                                        CLK,
  input  logic                                        RESET,
  input  logic                                        FREEZE,
  // Decode queue
  input  logic                                        decodeEmpty,
  output logic                                        decodePop,
  input  renamePkg::archReg_t                         srcArch1,
  input  renamePkg::archReg_t                         srcArch2,
  input  renamePkg::archReg_t                         destArch,
  input  logic                                        regWrite,
  input  logic                                        link,
  input  logic                                        memRead,
  input  logic                                        memWrite,
  input  logic [renamePkg::PAYLOAD_WIDTH-1:0]         payload,
  // Issue queue, LSQ and ROB
  input  logic                                        iqFull,
  input  logic                                        lsqFull,
  input  logic                                        robFull,
  input  renamePkg::robIdx_t                          robTail,
  output logic                                        iqPush,
  output logic                                        lsqPush,
  output logic                                        robPush,
  output renamePkg::dispatchPacket_t                  issuePacket,
  // Commit returns
  input  logic                                        freeReq,
  input  renamePkg::physTag_t                         freeTag,
  output logic                                        freeFull,
  // Recovery
  input  logic                                        restoreReq,
  input  renamePkg::physTag_t [renamePkg::ARCH_REGS-1:0] restoreMap
);

  renamePkg::physTag_t physSrc1;
  renamePkg::physTag_t physSrc2;
  renamePkg::physTag_t physDest;
  renamePkg::physTag_t freeHead;
  logic                freeEmpty;
  logic                freePop;
  logic                renameWrite;

  renameTable i_renameTable (
    .CLK        (CLK),
    .RESET      (RESET),
    .srcArch1   (srcArch1),
    .srcArch2   (srcArch2),
    .physSrc1   (physSrc1),
    .physSrc2   (physSrc2),
    .renameWrite(renameWrite),
    .writeArch  (destArch),
    .writeTag   (physDest),
    .restoreReq (restoreReq),
    .restoreMap (restoreMap)
  );

  freeList i_freeList (
    .CLK    (CLK),
    .RESET  (RESET),
    .popReq (freePop),
    .headTag(freeHead),
    .empty  (freeEmpty),
    .pushReq(freeReq),
    .pushTag(freeTag),
    .full   (freeFull)
  );

  dispatchControl i_dispatchControl (
    .CLK        (CLK),
    .RESET      (RESET),
    .FREEZE     (FREEZE),
    .decodeEmpty(decodeEmpty),
    .decodePop  (decodePop),
    .destArch   (destArch),
    .regWrite   (regWrite),
    .link       (link),
    .memRead    (memRead),
    .memWrite   (memWrite),
    .payload    (payload),
    .physSrc1   (physSrc1),
    .physSrc2   (physSrc2),
    .freeHead   (freeHead),
    .freeEmpty  (freeEmpty),
    .freePop    (freePop),
    .renameWrite(renameWrite),
    .physDest   (physDest),
    .iqFull     (iqFull),
    .lsqFull    (lsqFull),
    .robFull    (robFull),
    .robTail    (robTail),
    .iqPush     (iqPush),
    .lsqPush    (lsqPush),
    .robPush    (robPush),
    .issuePacket(issuePacket)
  );

endmodule

//--- hw/dispatchControl.sv
////////////////////////////////////////////////////////////
// Any stall holds the decode head with no pop; the packet and
// push strobes follow the pop by exactly one cycle
////////////////////////////////////////////////////////////

module dispatchControl (
  input  logic                               CLK,
  input  logic                               RESET,
  input  logic                               FREEZE,
  // Decode queue head
  input  logic                               decodeEmpty,
  output logic                               decodePop,
  input  renamePkg::archReg_t                destArch,
  input  logic                               regWrite,
  input  logic                               link,
  input  logic                               memRead,
  input  logic                               memWrite,
  input  logic [renamePkg::PAYLOAD_WIDTH-1:0] payload,
  // Source tags from the rename table
  input  renamePkg::physTag_t                physSrc1,
  input  renamePkg::physTag_t                physSrc2,
  // Free list
  input  renamePkg::physTag_t                freeHead,
  input  logic                               freeEmpty,
  output logic                               freePop,
  // Rename table write
  output logic                               renameWrite,
  output renamePkg::physTag_t                physDest,
  // Downstream queues
  input  logic                               iqFull,
  input  logic                               lsqFull,
  input  logic                               robFull,
  input  renamePkg::robIdx_t                 robTail,
  output logic                               iqPush,
  output logic                               lsqPush,
  output logic                               robPush,
  output renamePkg::dispatchPacket_t         issuePacket
);

  logic destNeeded;
  logic isMem;
  logic targetFull;
  logic advance;
  renamePkg::dispatchPacket_t nextPacket;

  assign destNeeded = regWrite || link;
  assign isMem = memRead || memWrite;

  // Only the queue the instruction goes to can hold it back
  assign targetFull = isMem ? lsqFull : iqFull;

  assign advance = !FREEZE && !decodeEmpty && !robFull && !targetFull &&
                   !(destNeeded && freeEmpty);

  assign decodePop = advance;
  assign freePop = advance && destNeeded;
  assign renameWrite = advance && destNeeded;
  assign physDest = destNeeded ? freeHead : '0;

  always_comb begin
    nextPacket.payload = payload;
    nextPacket.robTail = robTail;
    nextPacket.physSrc1 = physSrc1;
    nextPacket.physSrc2 = physSrc2;
    nextPacket.physDest = physDest;
    nextPacket.archDest = destArch;
    nextPacket.destNeeded = destNeeded;
    nextPacket.isMem = isMem;
  end

  // Push strobes, one cycle after the pop
  always_ff @(posedge CLK) begin
    if (!RESET) begin
      iqPush <= 1'b0;
      lsqPush <= 1'b0;
      robPush <= 1'b0;
    end else begin
      iqPush <= advance && !isMem;
      lsqPush <= advance && isMem;
      robPush <= advance;
    end
  end

  // Packet holds between pushes
  always_ff @(posedge CLK) begin
    if (advance) begin
      issuePacket <= nextPacket;
    end
  end

endmodule

//--- hw/freeList.sv
////////////////////////////////////////////////////////////
// First word fall-through; a pushed tag reaches the head one
// cycle later at the earliest. Pops on empty are dropped
////////////////////////////////////////////////////////////

module freeList (
  input  logic                CLK,
  input  logic                RESET,
  // Allocation side
  input  logic                popReq,
  output renamePkg::physTag_t headTag,
  output logic                empty,
  // Commit side
  input  logic                pushReq,
  input  renamePkg::physTag_t pushTag,
  output logic                full
);

  renamePkg::physTag_t fifoMem [renamePkg::PHYS_REGS];

  // Pointers span exactly PHYS_REGS entries and wrap by overflow
  logic [renamePkg::TAG_WIDTH-1:0]   rdPtr;
  logic [renamePkg::TAG_WIDTH-1:0]   wrPtr;
  logic [renamePkg::COUNT_WIDTH-1:0] count;

  logic doPop;
  logic doPush;

  assign empty = (count == '0);
  assign full = (count == renamePkg::COUNT_WIDTH'(renamePkg::PHYS_REGS));

  assign doPop = popReq && !empty;
  assign doPush = pushReq && !full;

  // Storage, preloaded with the tags above the identity map
  always_ff @(posedge CLK) begin
    if (!RESET) begin
      for (int i = 0; i < renamePkg::FREE_TAGS; i++) begin
        fifoMem[i] <= renamePkg::physTag_t'(renamePkg::ARCH_REGS + i);
      end
    end else if (doPush) begin
      fifoMem[wrPtr] <= pushTag;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESET) begin
      rdPtr <= '0;
      wrPtr <= renamePkg::TAG_WIDTH'(renamePkg::FREE_TAGS);
      count <= renamePkg::COUNT_WIDTH'(renamePkg::FREE_TAGS);
    end else begin
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (doPush && !doPop) begin
        count <= count + 1'b1;
      end else if (doPop && !doPush) begin
        count <= count - 1'b1;
      end
    end
  end

  assign headTag = fifoMem[rdPtr];

endmodule

//--- hw/renameTable.sv
////////////////////////////////////////////////////////////
// Reads are combinational; a write shows from the next cycle
// A restore wins over a rename write in the same cycle
////////////////////////////////////////////////////////////

module renameTable (
  input  logic                                        CLK,
  input  logic                                        RESET,
  // Source lookups
  input  renamePkg::archReg_t                         srcArch1,
  input  renamePkg::archReg_t                         srcArch2,
  output renamePkg::physTag_t                         physSrc1,
  output renamePkg::physTag_t                         physSrc2,
  // Rename write of one destination
  input  logic                                        renameWrite,
  input  renamePkg::archReg_t                         writeArch,
  input  renamePkg::physTag_t                         writeTag,
  // Recovery image, entry i in slice i
  input  logic                                        restoreReq,
  input  renamePkg::physTag_t [renamePkg::ARCH_REGS-1:0] restoreMap
);

  // Architectural to physical map
  renamePkg::physTag_t mapTable [renamePkg::ARCH_REGS];

  always_ff @(posedge CLK) begin
    if (!RESET) begin
      // Identity map, register i lives in tag i
      for (int i = 0; i < renamePkg::ARCH_REGS; i++) begin
        mapTable[i] <= renamePkg::physTag_t'(i);
      end
    end else if (restoreReq) begin
      for (int i = 0; i < renamePkg::ARCH_REGS; i++) begin
        mapTable[i] <= restoreMap[i];
      end
    end else if (renameWrite) begin
      mapTable[writeArch] <= writeTag;
    end
  end

  // Lookups see the table as it stood before the edge
  assign physSrc1 = mapTable[srcArch1];
  assign physSrc2 = mapTable[srcArch2];

endmodule

//--- hw/renamePkg.sv
////////////////////////////////////////////////////////////
// Sizes assume a power-of-two physical register count so the
// free list pointers wrap on their own
////////////////////////////////////////////////////////////

package renamePkg;

  // Register file sizes
  localparam int ARCH_REGS = 32;
  localparam int PHYS_REGS = 64;

  // Tags left for renaming once the identity map is taken
  localparam int FREE_TAGS = PHYS_REGS - ARCH_REGS;

  // Opaque decode fields (immediate, ALU control, PC, jump and branch)
  localparam int PAYLOAD_WIDTH = 64;
  localparam int ROB_IDX_WIDTH = 6;

  // Derived widths
  localparam int ARCH_WIDTH = $clog2(ARCH_REGS);
  localparam int TAG_WIDTH = $clog2(PHYS_REGS);
  localparam int COUNT_WIDTH = $clog2(PHYS_REGS + 1);

  typedef logic [ARCH_WIDTH-1:0] archReg_t;
  typedef logic [TAG_WIDTH-1:0] physTag_t;
  typedef logic [ROB_IDX_WIDTH-1:0] robIdx_t;

  // Packet shared by the issue queue, the LSQ and the ROB
  typedef struct packed {
    logic [PAYLOAD_WIDTH-1:0] payload;
    robIdx_t                  robTail;
    physTag_t                 physSrc1;
    physTag_t                 physSrc2;
    // Zero when the instruction writes no register
    physTag_t                 physDest;
    archReg_t                 archDest;
    logic                     destNeeded;
    // Selects the LSQ over the issue queue
    logic                     isMem;
  } dispatchPacket_t;

endpackage
